//--- design/tcdm_defs.svh
////////////////////////////////////////////////////////////
// Global sizes of the TCDM subsystem
// Requester and bank counts, word and address widths,
// bank depth and the address field widths
////////////////////////////////////////////////////////////

`ifndef TCDM_DEFS_SVH
`define TCDM_DEFS_SVH

// Requesters and banks, both powers of two
`define TCDM_NUM_IN       4
`define TCDM_NUM_OUT      4

// Byte address and data word
`define TCDM_ADDR_WIDTH   32
`define TCDM_DATA_WIDTH   32
`define TCDM_BE_WIDTH     4

// Bank geometry
`define TCDM_BANK_ROWS    64
`define TCDM_ROW_WIDTH    6
`define TCDM_BANK_WIDTH   2

// Byte offset inside a word and the ignored upper bits
`define TCDM_OFFSET_WIDTH 2
`define TCDM_TAG_WIDTH    (`TCDM_ADDR_WIDTH - `TCDM_ROW_WIDTH - `TCDM_BANK_WIDTH - `TCDM_OFFSET_WIDTH)

`endif

//--- design/tcdm_pkg.sv
////////////////////////////////////////////////////////////
// TCDM shared types
// Bank, requester and row index types and the address
// word that is read either raw or split into fields
////////////////////////////////////////////////////////////

`include "tcdm_defs.svh"

package tcdm_pkg;

    typedef logic [`TCDM_BANK_WIDTH-1:0] bank_idx_t;
    typedef logic [$clog2(`TCDM_NUM_IN)-1:0] req_idx_t;
    typedef logic [`TCDM_ROW_WIDTH-1:0] row_t;

    // Word interleaving puts the bank index right above the byte offset,
    // so consecutive words land in consecutive banks
    typedef struct packed {
        logic [`TCDM_TAG_WIDTH-1:0]    tag;
        row_t                          row;
        bank_idx_t                     bank;
        logic [`TCDM_OFFSET_WIDTH-1:0] offset;
    } tcdm_addr_fields_t;

    typedef union packed {
        logic [`TCDM_ADDR_WIDTH-1:0] raw;
        tcdm_addr_fields_t           f;
    } tcdm_addr_u;

endpackage

//--- design/tcdm_bank_arbiter.sv
////////////////////////////////////////////////////////////
// Per-bank round-robin arbiter
// Decodes each request to its bank, picks one winner per
// bank and returns the combined grant to the requesters
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_bank_arbiter import tcdm_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  logic       [`TCDM_NUM_IN-1:0]   req_i,
    input  tcdm_addr_u [`TCDM_NUM_IN-1:0]   add_i,
    output logic       [`TCDM_NUM_IN-1:0]   gnt_o,

    output logic       [`TCDM_NUM_OUT-1:0]  bank_req_o,
    output req_idx_t   [`TCDM_NUM_OUT-1:0]  bank_sel_o
);

    for (genvar b = 0; b < `TCDM_NUM_OUT; b++) begin : gen_bank
        logic [`TCDM_NUM_IN-1:0] match;
        req_idx_t                ptr_q;
        logic                    win_req;
        req_idx_t                win_sel;

        for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_match
            assign match[i] = req_i[i] && (add_i[i].f.bank == bank_idx_t'(b));
        end

        // Walk from the farthest candidate back to the pointer so that the
        // first match at or after the pointer is the one left standing
        always_comb begin
            req_idx_t cand;
            win_req = 1'b0;
            win_sel = '0;
            for (int k = `TCDM_NUM_IN - 1; k >= 0; k--) begin
                cand = ptr_q + req_idx_t'(k);
                if (match[cand]) begin
                    win_req = 1'b1;
                    win_sel = cand;
                end
            end
        end

        // Pointer moves past the winner only when this bank granted
        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                ptr_q <= '0;
            end else if (win_req) begin
                ptr_q <= win_sel + req_idx_t'(1);
            end
        end

        assign bank_req_o[b] = win_req;
        assign bank_sel_o[b] = win_sel;
    end

    ////////////////////////////////////////////////////////////
    // Grant back to requesters
    ////////////////////////////////////////////////////////////

    // A requester targets one bank only, so at most one bank can select it
    always_comb begin
        gnt_o = '0;
        for (int b = 0; b < `TCDM_NUM_OUT; b++) begin
            if (bank_req_o[b]) begin
                gnt_o[bank_sel_o[b]] = 1'b1;
            end
        end
    end

endmodule

//--- design/tcdm_req_xbar.sv
////////////////////////////////////////////////////////////
// Request crossbar
// Steers the winning requester's fields onto each bank port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_req_xbar import tcdm_pkg::*; (
    input  tcdm_addr_u [`TCDM_NUM_IN-1:0]                       add_i,
    input  logic       [`TCDM_NUM_IN-1:0]                       wen_i,
    input  logic       [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] wdata_i,
    input  logic       [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   be_i,

    input  logic       [`TCDM_NUM_OUT-1:0]                      bank_req_i,
    input  req_idx_t   [`TCDM_NUM_OUT-1:0]                      bank_sel_i,

    output logic       [`TCDM_NUM_OUT-1:0]                      mem_req_o,
    output logic       [`TCDM_NUM_OUT-1:0]                      mem_wen_o,
    output row_t       [`TCDM_NUM_OUT-1:0]                      mem_row_o,
    output logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0]      mem_wdata_o,
    output logic [`TCDM_NUM_OUT-1:0][`TCDM_BE_WIDTH-1:0]        mem_be_o
);

    // The bank field is already implied by which port the request
    // lands on, so only the row travels to the bank
    always_comb begin
        req_idx_t sel;
        for (int b = 0; b < `TCDM_NUM_OUT; b++) begin
            sel            = bank_sel_i[b];
            mem_req_o[b]   = bank_req_i[b];
            mem_wen_o[b]   = wen_i[sel];
            mem_row_o[b]   = add_i[sel].f.row;
            mem_wdata_o[b] = wdata_i[sel];
            mem_be_o[b]    = be_i[sel];
        end
    end

endmodule

//--- design/tcdm_rsp_xbar.sv
////////////////////////////////////////////////////////////
// Response crossbar
// Remembers which bank served each granted requester and
// returns that bank's read data with a valid a cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_rsp_xbar import tcdm_pkg::*; (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,

    input  logic       [`TCDM_NUM_IN-1:0]                       gnt_i,
    input  tcdm_addr_u [`TCDM_NUM_IN-1:0]                       add_i,
    input  logic       [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0] mem_rdata_i,

    output logic       [`TCDM_NUM_IN-1:0]                       vld_o,
    output logic       [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] rdata_o
);

    logic      [`TCDM_NUM_IN-1:0] vld_q;
    bank_idx_t [`TCDM_NUM_IN-1:0] bank_q;

    // One valid per grant, for reads and writes alike
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= gnt_i;
        end
    end

    // Remember which bank serves each granted requester
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `TCDM_NUM_IN; i++) begin
            if (gnt_i[i]) begin
                bank_q[i] <= add_i[i].f.bank;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Return path
    ////////////////////////////////////////////////////////////

    assign vld_o = vld_q;

    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_rsp
        assign rdata_o[i] = mem_rdata_i[bank_q[i]];
    end

endmodule

//--- design/tcdm_sram_bank.sv
////////////////////////////////////////////////////////////
// Single-port word SRAM bank
// Byte-enable writes and registered one-cycle reads
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_sram_bank import tcdm_pkg::*; (
    input  logic                         clk_i,

    input  logic                         req_i,
    input  logic                         wen_i,
    input  row_t                         row_i,
    input  logic [`TCDM_DATA_WIDTH-1:0]  wdata_i,
    input  logic [`TCDM_BE_WIDTH-1:0]    be_i,

    output logic [`TCDM_DATA_WIDTH-1:0]  rdata_o
);

    localparam int unsigned ByteWidth = `TCDM_DATA_WIDTH / `TCDM_BE_WIDTH;

    logic [`TCDM_DATA_WIDTH-1:0] mem_q [`TCDM_BANK_ROWS];

    // Write merges enabled bytes into the row; a read captures
    // the whole row for the response cycle
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (wen_i) begin
                for (int k = 0; k < `TCDM_BE_WIDTH; k++) begin
                    if (be_i[k]) begin
                        mem_q[row_i][k*ByteWidth +: ByteWidth] <=
                            wdata_i[k*ByteWidth +: ByteWidth];
                    end
                end
            end else begin
                rdata_o <= mem_q[row_i];
            end
        end
    end

endmodule

//--- design/tcdm_subsystem_top.sv
////////////////////////////////////////////////////////////
// TCDM subsystem top level
// Four requesters, round-robin bank arbitration, request and
// response crossbars and four interleaved SRAM banks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_subsystem_top import tcdm_pkg::*; (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,

    input  logic [`TCDM_NUM_IN-1:0]                       req_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] add_i,
    input  logic [`TCDM_NUM_IN-1:0]                       wen_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] wdata_i,
    input  logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   be_i,

    output logic [`TCDM_NUM_IN-1:0]                       gnt_o,
    output logic [`TCDM_NUM_IN-1:0]                       vld_o,
    output logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] rdata_o
);

    tcdm_addr_u [`TCDM_NUM_IN-1:0]                        add_u;

    logic       [`TCDM_NUM_OUT-1:0]                       bank_req;
    req_idx_t   [`TCDM_NUM_OUT-1:0]                       bank_sel;

    logic       [`TCDM_NUM_OUT-1:0]                       mem_req;
    logic       [`TCDM_NUM_OUT-1:0]                       mem_wen;
    row_t       [`TCDM_NUM_OUT-1:0]                       mem_row;
    logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0]       mem_wdata;
    logic [`TCDM_NUM_OUT-1:0][`TCDM_BE_WIDTH-1:0]         mem_be;
    logic [`TCDM_NUM_OUT-1:0][`TCDM_DATA_WIDTH-1:0]       mem_rdata;

    // Requesters hand in plain byte addresses
    for (genvar i = 0; i < `TCDM_NUM_IN; i++) begin : gen_addr
        assign add_u[i].raw = add_i[i];
    end

    tcdm_bank_arbiter i_arbiter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .add_i      (add_u),
        .gnt_o      (gnt_o),
        .bank_req_o (bank_req),
        .bank_sel_o (bank_sel)
    );

    tcdm_req_xbar i_req_xbar (
        .add_i       (add_u),
        .wen_i       (wen_i),
        .wdata_i     (wdata_i),
        .be_i        (be_i),
        .bank_req_i  (bank_req),
        .bank_sel_i  (bank_sel),
        .mem_req_o   (mem_req),
        .mem_wen_o   (mem_wen),
        .mem_row_o   (mem_row),
        .mem_wdata_o (mem_wdata),
        .mem_be_o    (mem_be)
    );

    ////////////////////////////////////////////////////////////
    // Banks
    ////////////////////////////////////////////////////////////

    for (genvar b = 0; b < `TCDM_NUM_OUT; b++) begin : gen_bank
        tcdm_sram_bank i_bank (
            .clk_i   (clk_i),
            .req_i   (mem_req[b]),
            .wen_i   (mem_wen[b]),
            .row_i   (mem_row[b]),
            .wdata_i (mem_wdata[b]),
            .be_i    (mem_be[b]),
            .rdata_o (mem_rdata[b])
        );
    end

    tcdm_rsp_xbar i_rsp_xbar (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .gnt_i       (gnt_o),
        .add_i       (add_u),
        .mem_rdata_i (mem_rdata),
        .vld_o       (vld_o),
        .rdata_o     (rdata_o)
    );

endmodule

//--- verification/tcdm_tb.sv
////////////////////////////////////////////////////////////
// Directed testbench for the TCDM subsystem
// Clock, reset, a reference memory by bank and row, and
// tests for reset, byte enables, parallel banks, bank
// conflicts and random traffic
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_defs.svh"

module tcdm_tb import tcdm_pkg::*; ();

    localparam int Timeout     = 20;
    localparam int ResetCycles = 5;
    localparam int ByteWidth   = `TCDM_DATA_WIDTH / `TCDM_BE_WIDTH;

    logic                                          clk;
    logic                                          rst_n;
    logic [`TCDM_NUM_IN-1:0]                       req;
    logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] add;
    logic [`TCDM_NUM_IN-1:0]                       wen;
    logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] wdata;
    logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   be;
    logic [`TCDM_NUM_IN-1:0]                       gnt;
    logic [`TCDM_NUM_IN-1:0]                       vld;
    logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] rdata;

    // Operations a test sets up before it runs a group of requests
    logic [`TCDM_NUM_IN-1:0][`TCDM_ADDR_WIDTH-1:0] op_addr;
    logic [`TCDM_NUM_IN-1:0]                       op_wen;
    logic [`TCDM_NUM_IN-1:0][`TCDM_DATA_WIDTH-1:0] op_wdata;
    logic [`TCDM_NUM_IN-1:0][`TCDM_BE_WIDTH-1:0]   op_be;
    int                                            grant_cycle [`TCDM_NUM_IN];
    int                                            grant_order [$];

    logic [`TCDM_DATA_WIDTH-1:0] ref_mem [`TCDM_NUM_OUT][`TCDM_BANK_ROWS];
    bit                          known   [`TCDM_NUM_OUT][`TCDM_BANK_ROWS];

    integer seed         = 32'he523_807d;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    tcdm_subsystem_top dut0 (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .add_i   (add),
        .wen_i   (wen),
        .wdata_i (wdata),
        .be_i    (be),
        .gnt_o   (gnt),
        .vld_o   (vld),
        .rdata_o (rdata)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [`TCDM_ADDR_WIDTH-1:0] make_addr(
        input logic [`TCDM_TAG_WIDTH-1:0] tag, input row_t row, input bank_idx_t bank);
        return {tag, row, bank, {`TCDM_OFFSET_WIDTH{1'b0}}};
    endfunction

    function automatic logic [`TCDM_DATA_WIDTH-1:0] merge_bytes(
        input logic [`TCDM_DATA_WIDTH-1:0] old, input logic [`TCDM_DATA_WIDTH-1:0] data,
        input logic [`TCDM_BE_WIDTH-1:0] en);
        logic [`TCDM_DATA_WIDTH-1:0] res;
        res = old;
        for (int k = 0; k < `TCDM_BE_WIDTH; k++) begin
            if (en[k]) begin
                res[k*ByteWidth +: ByteWidth] = data[k*ByteWidth +: ByteWidth];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic clear_ops();
        op_addr  = '0;
        op_wen   = '0;
        op_wdata = '0;
        op_be    = '0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s %0d error(s)", name, errors - errors_before);
        end
    endtask

    task automatic apply_reset(input string name);
        @(posedge clk);
        rst_n <= 1'b0;
        req   <= '0;
        for (int c = 0; c < ResetCycles; c++) begin
            @(negedge clk);
            check_value(name, "gnt in reset", 32'd0, 32'(gnt));
            check_value(name, "vld in reset", 32'd0, 32'(vld));
            @(posedge clk);
        end
        rst_n <= 1'b1;
    endtask

    // Issues the set-up operations of the masked requesters together, holds
    // each request until granted and checks the response one cycle later
    task automatic run_group(input string name, input logic [`TCDM_NUM_IN-1:0] mask);
        logic [`TCDM_NUM_IN-1:0]     pending;
        logic [`TCDM_NUM_IN-1:0]     vld_due;
        logic [`TCDM_DATA_WIDTH-1:0] exp_rdata [`TCDM_NUM_IN];
        tcdm_addr_u                  a;
        int                          cycles;
        @(posedge clk);
        req     <= mask;
        add     <= op_addr;
        wen     <= op_wen;
        wdata   <= op_wdata;
        be      <= op_be;
        pending = mask;
        vld_due = '0;
        cycles  = 0;
        grant_order.delete();
        while ((pending != '0 || vld_due != '0) && cycles < Timeout) begin
            @(negedge clk);
            check_value(name, "vld", 32'(vld_due), 32'(vld));
            for (int i = 0; i < `TCDM_NUM_IN; i++) begin
                if (vld_due[i] && !op_wen[i]) begin
                    check_value(name, $sformatf("rdata[%0d]", i), exp_rdata[i], rdata[i]);
                end
            end
            vld_due = '0;
            assert ((gnt & ~pending) == '0) else begin
                $display("Grant without a pending request in %s: gnt %b", name, gnt);
                errors++;
            end
            for (int i = 0; i < `TCDM_NUM_IN; i++) begin
                if (pending[i] && gnt[i]) begin
                    a.raw          = op_addr[i];
                    grant_cycle[i] = cycles;
                    grant_order.push_back(i);
                    exp_rdata[i]   = ref_mem[a.f.bank][a.f.row];
                    if (op_wen[i]) begin
                        ref_mem[a.f.bank][a.f.row] =
                            merge_bytes(exp_rdata[i], op_wdata[i], op_be[i]);
                        if (op_be[i] == '1) begin
                            known[a.f.bank][a.f.row] = 1'b1;
                        end
                    end
                    pending[i] = 1'b0;
                    vld_due[i] = 1'b1;
                end
            end
            @(posedge clk);
            req <= pending;
            cycles++;
        end
        assert (pending == '0 && vld_due == '0) else begin
            $display("Timeout in %s: requests or responses still open after %0d cycles",
                     name, Timeout);
            errors++;
        end
        req <= '0;
        @(negedge clk);
        check_value(name, "vld after response", 32'd0, 32'(vld));
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset(input string name);
        int e0;
        e0 = errors;
        apply_reset(name);
        repeat (2) begin
            @(negedge clk);
            check_value(name, "gnt after reset", 32'd0, 32'(gnt));
            check_value(name, "vld after reset", 32'd0, 32'(vld));
        end
        report_test(name, e0);
    endtask

    task automatic test_single(input string name);
        int e0;
        e0 = errors;
        clear_ops();
        op_addr[2]  = make_addr('0, 6'd5, 2'd1);
        op_wen[2]   = 1'b1;
        op_wdata[2] = $random(seed);
        op_be[2]    = 4'hf;
        run_group(name, 4'b0100);
        check_value(name, "full write grant cycle", 32'd0, grant_cycle[2]);
        op_wdata[2] = $random(seed);
        op_be[2]    = 4'b0101;
        run_group(name, 4'b0100);
        check_value(name, "partial write grant cycle", 32'd0, grant_cycle[2]);
        op_wen[2] = 1'b0;
        run_group(name, 4'b0100);
        check_value(name, "read grant cycle", 32'd0, grant_cycle[2]);
        report_test(name, e0);
    endtask

    task automatic test_parallel(input string name);
        int e0;
        e0 = errors;
        clear_ops();
        for (int i = 0; i < `TCDM_NUM_IN; i++) begin
            op_addr[i]  = make_addr('0, row_t'(10 + i), bank_idx_t'(3 - i));
            op_wen[i]   = 1'b1;
            op_wdata[i] = $random(seed);
            op_be[i]    = '1;
        end
        for (int pass = 0; pass < 2; pass++) begin
            run_group(name, '1);
            for (int i = 0; i < `TCDM_NUM_IN; i++) begin
                check_value(name, $sformatf("grant cycle[%0d]", i), 32'd0, grant_cycle[i]);
            end
            op_wen = '0;
        end
        report_test(name, e0);
    endtask

    task automatic test_conflict(input string name);
        int e0;
        e0 = errors;
        // Pointers start from requester 0 again after this reset
        apply_reset(name);
        clear_ops();
        for (int i = 0; i < `TCDM_NUM_IN; i++) begin
            op_addr[i]  = make_addr('0, row_t'(20 + i), 2'd2);
            op_wen[i]   = 1'b1;
            op_wdata[i] = $random(seed);
            op_be[i]    = '1;
        end
        for (int pass = 0; pass < 2; pass++) begin
            run_group(name, '1);
            check_value(name, "grants seen", `TCDM_NUM_IN, grant_order.size());
            for (int i = 0; i < grant_order.size(); i++) begin
                check_value(name, $sformatf("grant order[%0d]", i), i, grant_order[i]);
                check_value(name, $sformatf("grant cycle[%0d]", i), i, grant_cycle[i]);
            end
            op_wen = '0;
        end
        report_test(name, e0);
    endtask

    task automatic test_random(input string name);
        int                      e0;
        logic [`TCDM_NUM_IN-1:0] mask;
        tcdm_addr_u              a;
        e0 = errors;
        // Same bank and row through a nonzero tag reads the same word
        clear_ops();
        op_addr[1]  = make_addr('0, 6'd33, 2'd3);
        op_wen[1]   = 1'b1;
        op_wdata[1] = $random(seed);
        op_be[1]    = '1;
        run_group(name, 4'b0010);
        op_addr[1] = make_addr(22'h2a5c1, 6'd33, 2'd3);
        op_wen[1]  = 1'b0;
        run_group(name, 4'b0010);
        for (int round = 0; round < 60; round++) begin
            mask = 4'($random(seed));
            if (mask == '0) begin
                mask = 4'b0001;
            end
            for (int i = 0; i < `TCDM_NUM_IN; i++) begin
                // Keep rows 0 to 7 so that reads hit words written earlier
                a.raw       = $random(seed) & 32'hffff_fc7f;
                op_addr[i]  = a.raw;
                op_wdata[i] = $random(seed);
                if (known[a.f.bank][a.f.row]) begin
                    op_wen[i] = 1'($random(seed));
                    op_be[i]  = 4'($random(seed));
                end else begin
                    op_wen[i] = 1'b1;
                    op_be[i]  = '1;
                end
            end
            run_group(name, mask);
        end
        report_test(name, e0);
    endtask

    initial begin
        rst_n = 1'b0;
        req   = '0;
        add   = '0;
        wen   = '0;
        wdata = '0;
        be    = '0;
        clear_ops();
        test_reset("reset");
        test_single("single_be");
        test_parallel("parallel_banks");
        test_conflict("bank_conflict");
        test_random("random_traffic");
        $display("tests run %0d, failing tests %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/tcdm_pkg.sv
design/tcdm_bank_arbiter.sv
design/tcdm_req_xbar.sv
design/tcdm_rsp_xbar.sv
design/tcdm_sram_bank.sv
design/tcdm_subsystem_top.sv
verification/tcdm_tb.sv

//--- Makefile
# Verilator flow for the TCDM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcdm_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
